// ==== cpuCore.f ====
src/cpuPkg.sv
src/registerFile.sv
src/instructionDecoder.sv
src/fetchUnit.sv
src/executeUnit.sv
src/busArbiter.sv
src/cpuCore.sv
verification/cpuCore_chk.sv
verification/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f cpuCore.f --top-module cpuCoreTb -o cpuCoreSim

./obj_dir/cpuCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
  exit 1
fi

// ==== verification/cpuCoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb;

  localparam int            SEED           = 60608;
  localparam int            PROG_LEN       = 120;
  localparam int            CODE_END       = 144;  // code below, data region from here up
  localparam int            TIMEOUT_CYCLES = (PROG_LEN + 8) * 20;
  localparam cpuPkg::word_t NOP            = 16'h0800;

  logic            clk;
  logic            rst;
  logic            busReqReady;
  logic            busRspValid;
  cpuPkg::word_t   busRspData;
  logic            busReqValid;
  cpuPkg::memReq_t busReq;

  cpuPkg::word_t   busMem [256];   // memory behind the bus
  cpuPkg::word_t   refMem [256];   // model memory
  cpuPkg::word_t   refRegs [8];    // model r0..r7
  cpuPkg::word_t   refSp;
  cpuPkg::memReq_t dataQ [$];      // data accesses in program order
  int              dataCount;
  int              dataIdx;
  int              progLen;
  cpuPkg::word_t   fetchPc;
  logic            rspPending;
  int              rspWait;
  cpuPkg::word_t   rspWord;
  logic            accepted;       // transfer on the coming edge
  logic            passed = 1'b0;
  logic            failed = 1'b0;

  cpuCore dut_i (
    .clk, .rst, .busReqReady, .busRspValid, .busRspData, .busReqValid, .busReq
  );

  bind cpuCore cpuCore_chk chk_i (
    .clk(clk), .rst(rst), .busReqValid(busReqValid), .busReq(busReq),
    .busReqReady(busReqReady), .busRspValid(busRspValid)
  );

  task automatic stopOnError(input string msg);
    failed = 1'b1;
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic cpuPkg::word_t signExtend(input cpuPkg::word_t value, input int bits);
    return cpuPkg::word_t'($signed(value << (16 - bits)) >>> (16 - bits));
  endfunction

  task automatic emit(input cpuPkg::word_t inst);
    busMem[progLen] = inst;
    progLen++;
  endtask

  task automatic expectData(input cpuPkg::word_t addr, input cpuPkg::word_t wdata,
                            input logic write);
    cpuPkg::memReq_t req;
    req.addr  = addr;
    req.wdata = wdata;
    req.write = write;
    dataQ.push_back(req);
    if (write)
      refMem[addr[7:0]] = wdata;
  endtask

  // offset that puts an SP access into the data region
  task automatic pickSpOffset(output logic [7:0] imm8, output cpuPkg::word_t addr);
    logic [7:0] target;
    target = 8'(CODE_END + $urandom % (256 - CODE_END));
    imm8   = target - refSp[7:0];
    addr   = refSp + signExtend({8'd0, imm8}, 8);
  endtask

  task automatic loadSp(input logic [2:0] rx);
    logic [7:0]    imm8;
    cpuPkg::word_t addr;
    pickSpOffset(imm8, addr);
    emit({5'b10010, rx, imm8});
    expectData(addr, '0, 1'b0);
    refRegs[rx] = refMem[addr[7:0]];
  endtask

  task automatic storeSp(input logic [2:0] rx);
    logic [7:0]    imm8;
    cpuPkg::word_t addr;
    pickSpOffset(imm8, addr);
    emit({5'b11010, rx, imm8});
    expectData(addr, refRegs[rx], 1'b1);
  endtask

  // random program, executed on the model while it is written
  task automatic buildProgram();
    logic [2:0]    rx;
    logic [2:0]    ry;
    logic [2:0]    rz;
    logic [7:0]    imm8;
    logic [4:0]    imm5;
    cpuPkg::word_t addr;
    for (int a = 0; a < 256; a++)
      busMem[a] = (a < CODE_END) ? NOP : cpuPkg::word_t'($urandom);
    refMem = busMem;
    for (int r = 0; r < 8; r++)
      refRegs[r] = '0;
    refSp   = '0;
    progLen = 0;
    for (int i = 0; i < PROG_LEN; i++)
    begin
      rx   = 3'($urandom);
      ry   = 3'($urandom);
      rz   = 3'($urandom);
      imm8 = 8'($urandom);
      imm5 = 5'($urandom);
      case ($urandom % 16)
        0:
        begin
          emit({5'b01101, rx, imm8});  // li
          refRegs[rx] = {8'd0, imm8};
        end
        1:
        begin
          emit({5'b01001, rx, imm8});  // addiu
          refRegs[rx] = refRegs[rx] + signExtend({8'd0, imm8}, 8);
        end
        2:
        begin
          emit({5'b01000, rx, ry, 1'b0, imm5[3:0]});  // addiu3
          refRegs[ry] = refRegs[rx] + signExtend({12'd0, imm5[3:0]}, 4);
        end
        3:
        begin
          emit({5'b11100, rx, ry, rz, 2'b01});  // addu
          refRegs[rz] = refRegs[rx] + refRegs[ry];
        end
        4:
        begin
          emit({5'b11100, rx, ry, rz, 2'b11});  // subu
          refRegs[rz] = refRegs[rx] - refRegs[ry];
        end
        5:
        begin
          emit({5'b01111, rx, ry, 5'b00000});  // move
          refRegs[rx] = refRegs[ry];
        end
        6:
        begin
          emit({5'b11101, rx, ry, 5'b01100});  // and
          refRegs[rx] = refRegs[rx] & refRegs[ry];
        end
        7:
        begin
          emit({5'b11101, rx, ry, 5'b01101});  // or
          refRegs[rx] = refRegs[rx] | refRegs[ry];
        end
        8:
        begin
          emit({5'b01100, 3'b100, ry, 5'b00000});  // mtsp
          refSp = refRegs[ry];
        end
        9:
        begin
          emit({5'b01100, 3'b011, imm8});  // addsp
          refSp = refSp + signExtend({8'd0, imm8}, 8);
        end
        10:
        begin
          addr = refRegs[rx] + signExtend({11'd0, imm5}, 5);
          if (int'(addr[7:0]) >= CODE_END)
          begin
            emit({5'b10011, rx, ry, imm5});  // lw
            expectData(addr, '0, 1'b0);
            refRegs[ry] = refMem[addr[7:0]];
          end
          else
            loadSp(rx);  // would hit code, go through SP
        end
        11:
        begin
          addr = refRegs[ry] + signExtend({11'd0, imm5}, 5);
          if (int'(addr[7:0]) >= CODE_END)
          begin
            emit({5'b11011, rx, ry, imm5});  // sw
            expectData(addr, refRegs[rx], 1'b1);
          end
          else
            storeSp(rx);
        end
        12:
          loadSp(rx);
        13:
          storeSp(rx);
        default:
          case ($urandom % 6)
            0:       emit(NOP);
            1:       emit({5'b00010, imm8, ry});        // b
            2:       emit({5'b00100, rx, imm8});        // beqz
            3:       emit({5'b00101, rx, imm8});        // bnez
            4:       emit({5'b11101, rx, ry, 5'b01010}); // cmp
            default: emit({5'b11110, rx, 8'd0});         // mfih
          endcase
      endcase
    end
    for (int r = 0; r < 8; r++)
      storeSp(3'(r));  // expose every general register
    dataCount = dataQ.size();
  endtask

  task automatic serveRequest(output cpuPkg::word_t rdata);
    cpuPkg::memReq_t expReq;
    rdata  = '0;
    expReq = '0;
    if (dataIdx < dataCount)
      expReq = dataQ[dataIdx];
    if (busReq.write)
    begin
      assert (dataIdx < dataCount)
        else stopOnError("store request after the last expected data access");
      assert (expReq.write)
        else stopOnError($sformatf("mismatch busReq.write: got %h, expected %h",
                                   busReq.write, expReq.write));
      assert (busReq.addr == expReq.addr)
        else stopOnError($sformatf("mismatch busReq.addr: got %h, expected %h",
                                   busReq.addr, expReq.addr));
      assert (busReq.wdata == expReq.wdata)
        else stopOnError($sformatf("mismatch busReq.wdata: got %h, expected %h",
                                   busReq.wdata, expReq.wdata));
      busMem[busReq.addr[7:0]] = busReq.wdata;
      dataIdx++;
    end
    else if (busReq.addr == fetchPc)
    begin
      rdata   = busMem[fetchPc[7:0]];  // next instruction in order
      fetchPc = fetchPc + 16'd1;
    end
    else
    begin
      assert (dataIdx < dataCount && !expReq.write && busReq.addr == expReq.addr)
        else stopOnError($sformatf("mismatch busReq.addr: got %h, expected fetch %h or load %h",
                                   busReq.addr, fetchPc, expReq.addr));
      rdata = busMem[busReq.addr[7:0]];
      dataIdx++;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // memory model with random stalls and response latency
  initial
  begin
    void'($urandom(SEED));
    busReqReady = 1'b0;
    busRspValid = 1'b0;
    busRspData  = '0;
    rspPending  = 1'b0;
    rspWait     = 0;
    rspWord     = '0;
    accepted    = 1'b0;
    dataIdx     = 0;
    fetchPc     = cpuPkg::RESET_PC;
    buildProgram();
    forever
    begin
      @(negedge clk);
      accepted = !rst && busReqValid && busReqReady;  // settled mid-cycle
      if (accepted)
        serveRequest(rspWord);
      @(posedge clk);
      busRspValid <= 1'b0;
      busReqReady <= ($urandom % 4) != 0;  // stall about one cycle in four
      if (!rst && rspPending)
      begin
        if (rspWait == 0)
        begin
          busRspValid <= 1'b1;
          busRspData  <= rspWord;
          rspPending  = 1'b0;
        end
        else
          rspWait--;
      end
      if (accepted)
      begin
        rspPending = 1'b1;
        rspWait    = $urandom % 4;  // response 1 to 4 cycles later
      end
    end
  end

  initial
  begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    wait (dataIdx == dataCount);
    repeat (4) @(posedge clk);  // last store response drains
    passed = 1'b1;
    $display("TB PASSED");
    $finish;
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    stopOnError($sformatf("timeout: %0d of %0d data accesses seen after %0d cycles",
                          dataIdx, dataCount, TIMEOUT_CYCLES));
  end

  final
  begin
    if (!passed && !failed)
      $display("TB FAILED");  // stopped by a bound assertion
  end

endmodule

`default_nettype wire

// ==== verification/cpuCore_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCore_chk (
  input wire                  clk,
  input wire                  rst,
  input wire                  busReqValid,
  input wire cpuPkg::memReq_t busReq,
  input wire                  busReqReady,
  input wire                  busRspValid
);

  logic outstanding;  // transfer done, response not yet seen

  always_ff @(posedge clk)
  begin
    if (rst)
      outstanding <= 1'b0;
    else if (busReqValid && busReqReady)
      outstanding <= 1'b1;
    else if (busRspValid)
      outstanding <= 1'b0;
  end

  reqHeld: assert property (@(posedge clk) disable iff (rst)
    busReqValid && !busReqReady |=> busReqValid && $stable(busReq))
    else $error("bus request changed while stalled");

  singleOutstanding: assert property (@(posedge clk) disable iff (rst)
    outstanding |-> !(busReqValid && busReqReady))
    else $error("request transferred while a response is outstanding");

  idleAfterReset: assert property (@(posedge clk) rst |=> !busReqValid)
    else $error("busReqValid high in the cycle after reset");

endmodule

`default_nettype wire

// ==== src/cpuCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCore (
  input  wire                clk,
  input  wire                rst,
  input  wire                busReqReady,
  input  wire                busRspValid,
  input  wire cpuPkg::word_t busRspData,
  output logic               busReqValid,
  output cpuPkg::memReq_t    busReq
);

  logic               fetchReqValid;
  logic               fetchReqReady;
  cpuPkg::memReq_t    fetchReq;
  logic               fetchRspValid;
  logic               dataReqValid;
  logic               dataReqReady;
  cpuPkg::memReq_t    dataReq;
  logic               dataRspValid;
  logic               instValid;
  logic               instReady;
  cpuPkg::word_t      instWord;
  logic               opValid;
  logic               opReady;
  cpuPkg::decodedOp_t op;
  cpuPkg::regIdx_t    readS;
  cpuPkg::regIdx_t    readM;
  cpuPkg::word_t      dataS;
  cpuPkg::word_t      dataM;
  logic               writeEn;
  cpuPkg::regIdx_t    writeIdx;
  cpuPkg::word_t      writeData;

  fetchUnit fetch_i (
    .clk, .rst, .fetchReqReady, .fetchRspValid, .busRspData, .instReady,
    .fetchReqValid, .fetchReq, .instValid, .instWord
  );

  instructionDecoder decoder_i (
    .clk, .rst, .instValid, .instWord, .opReady,
    .instReady, .opValid, .op
  );

  registerFile regFile_i (
    .clk, .rst, .readS, .readM, .writeEn, .writeIdx, .writeData,
    .dataS, .dataM
  );

  executeUnit execute_i (
    .clk, .rst, .opValid, .op, .dataS, .dataM, .dataReqReady, .dataRspValid,
    .busRspData, .opReady, .readS, .readM, .dataReqValid, .dataReq,
    .writeEn, .writeIdx, .writeData
  );

  busArbiter arbiter_i (
    .clk, .rst, .fetchReqValid, .fetchReq, .dataReqValid, .dataReq,
    .busReqReady, .busRspValid, .fetchReqReady, .dataReqReady,
    .busReqValid, .busReq, .fetchRspValid, .dataRspValid
  );

endmodule

`default_nettype wire

// ==== src/busArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module busArbiter (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  fetchReqValid,
  input  wire cpuPkg::memReq_t fetchReq,
  input  wire                  dataReqValid,
  input  wire cpuPkg::memReq_t dataReq,
  input  wire                  busReqReady,
  input  wire                  busRspValid,
  output logic                 fetchReqReady,
  output logic                 dataReqReady,
  output logic                 busReqValid,
  output cpuPkg::memReq_t      busReq,
  output logic                 fetchRspValid,
  output logic                 dataRspValid
);

  logic grantFetch;  // owner of the outstanding request
  logic grantData;
  logic fetchHold;   // fetch already shown to the bus and stalled
  logic busy;
  logic pickData;

  assign busy = grantFetch || grantData;

  // data wins unless a stalled fetch request must stay on the bus
  assign pickData = dataReqValid && !fetchHold;

  assign busReqValid   = !busy && (dataReqValid || fetchReqValid);
  assign busReq        = pickData ? dataReq : fetchReq;
  assign dataReqReady  = !busy && pickData && busReqReady;
  assign fetchReqReady = !busy && !pickData && busReqReady;

  assign fetchRspValid = busRspValid && grantFetch;
  assign dataRspValid  = busRspValid && grantData;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantFetch <= 1'b0;
      grantData  <= 1'b0;
      fetchHold  <= 1'b0;
    end
    else if (busReqValid && busReqReady)
    begin
      grantData  <= pickData;
      grantFetch <= !pickData;
      fetchHold  <= 1'b0;
    end
    else
    begin
      if (busRspValid)
      begin
        grantFetch <= 1'b0;  // one response per request
        grantData  <= 1'b0;
      end
      if (busReqValid && !pickData)
        fetchHold <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     opValid,
  input  wire cpuPkg::decodedOp_t op,
  input  wire cpuPkg::word_t      dataS,
  input  wire cpuPkg::word_t      dataM,
  input  wire                     dataReqReady,
  input  wire                     dataRspValid,
  input  wire cpuPkg::word_t      busRspData,
  output logic                    opReady,
  output cpuPkg::regIdx_t         readS,
  output cpuPkg::regIdx_t         readM,
  output logic                    dataReqValid,
  output cpuPkg::memReq_t         dataReq,
  output logic                    writeEn,
  output cpuPkg::regIdx_t         writeIdx,
  output cpuPkg::word_t           writeData
);

  typedef enum logic [1:0] {EX_IDLE, EX_WRITE, EX_REQ, EX_WAIT} exState_t;

  exState_t           state;
  cpuPkg::decodedOp_t curOp;
  cpuPkg::word_t      aluResult;

  assign opReady = (state == EX_IDLE);
  assign readS   = curOp.registerS;
  assign readM   = curOp.registerM;

  always_comb
  begin
    case (curOp.opClass)
      cpuPkg::OP_LI:    aluResult = curOp.imm;
      cpuPkg::OP_ADDIU: aluResult = dataS + curOp.imm;
      cpuPkg::OP_ADDU:  aluResult = dataS + dataM;
      cpuPkg::OP_SUBU:  aluResult = dataS - dataM;
      cpuPkg::OP_MOVE:  aluResult = dataS;
      cpuPkg::OP_AND:   aluResult = dataS & dataM;
      cpuPkg::OP_OR:    aluResult = dataS | dataM;
      cpuPkg::OP_MTSP:  aluResult = dataS;
      cpuPkg::OP_ADDSP: aluResult = dataS + curOp.imm;
      default:          aluResult = '0;
    endcase
  end

  assign dataReqValid  = (state == EX_REQ);
  assign dataReq.addr  = dataS + curOp.imm;  // base plus offset
  assign dataReq.wdata = dataM;
  assign dataReq.write = (curOp.opClass == cpuPkg::OP_STORE);

  // lw result lands on the response edge
  assign writeEn   = (state == EX_WRITE) ||
                     (state == EX_WAIT && dataRspValid && curOp.opClass == cpuPkg::OP_LOAD);
  assign writeIdx  = curOp.registerT;
  assign writeData = (state == EX_WAIT) ? busRspData : aluResult;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= EX_IDLE;
    else
      case (state)
        EX_IDLE:
          if (opValid)
            case (op.opClass)
              cpuPkg::OP_NONE:  state <= EX_IDLE;  // retires right away
              cpuPkg::OP_LOAD,
              cpuPkg::OP_STORE: state <= EX_REQ;
              default:          state <= EX_WRITE;
            endcase
        EX_WRITE:
          state <= EX_IDLE;
        EX_REQ:
          if (dataReqReady)
            state <= EX_WAIT;
        default:
          if (dataRspValid)
            state <= EX_IDLE;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (state == EX_IDLE && opValid)
      curOp <= op;
  end

endmodule

`default_nettype wire

// ==== src/fetchUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
  input  wire                clk,
  input  wire                rst,
  input  wire                fetchReqReady,
  input  wire                fetchRspValid,
  input  wire cpuPkg::word_t busRspData,
  input  wire                instReady,
  output logic               fetchReqValid,
  output cpuPkg::memReq_t    fetchReq,
  output logic               instValid,
  output cpuPkg::word_t      instWord
);

  typedef enum logic [1:0] {FETCH_REQ, FETCH_WAIT, FETCH_OFFER} fetchState_t;

  fetchState_t   state;
  cpuPkg::word_t pc;

  assign fetchReqValid  = (state == FETCH_REQ);
  assign fetchReq.addr  = pc;
  assign fetchReq.wdata = '0;
  assign fetchReq.write = 1'b0;  // fetch only reads

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= FETCH_OFFER;  // empty offer slot, first request next cycle
      instValid <= 1'b0;
      pc        <= cpuPkg::RESET_PC;
    end
    else
      case (state)
        FETCH_REQ:
          if (fetchReqReady)
          begin
            pc    <= pc + 16'd1;
            state <= FETCH_WAIT;
          end
        FETCH_WAIT:
          if (fetchRspValid)
          begin
            instValid <= 1'b1;
            state     <= FETCH_OFFER;
          end
        default:
          if (!instValid || instReady)
          begin
            instValid <= 1'b0;
            state     <= FETCH_REQ;
          end
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (state == FETCH_WAIT && fetchRspValid)
      instWord <= busRspData;
  end

endmodule

`default_nettype wire

// ==== src/instructionDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder (
  input  wire                clk,
  input  wire                rst,
  input  wire                instValid,
  input  wire cpuPkg::word_t instWord,
  input  wire                opReady,
  output logic               instReady,
  output logic               opValid,
  output cpuPkg::decodedOp_t op
);

  cpuPkg::decodedOp_t nextOp;
  cpuPkg::regIdx_t    rx;
  cpuPkg::regIdx_t    ry;
  cpuPkg::regIdx_t    rz;
  cpuPkg::word_t      imm8Zero;
  cpuPkg::word_t      imm8Sign;
  cpuPkg::word_t      imm5Sign;
  cpuPkg::word_t      imm4Sign;

  assign rx       = {1'b0, instWord[10:8]};
  assign ry       = {1'b0, instWord[7:5]};
  assign rz       = {1'b0, instWord[4:2]};
  assign imm8Zero = {8'd0, instWord[7:0]};
  assign imm8Sign = {{8{instWord[7]}}, instWord[7:0]};
  assign imm5Sign = {{11{instWord[4]}}, instWord[4:0]};
  assign imm4Sign = {{12{instWord[3]}}, instWord[3:0]};

  assign instReady = !opValid || opReady;  // empty or draining this cycle

  always_comb
  begin
    nextOp           = '0;
    nextOp.opClass   = cpuPkg::OP_NONE;
    case (instWord[15:11])
      5'b00000:                            // addsp3
      begin
        nextOp.registerS = cpuPkg::REG_SP;
        nextOp.registerT = rx;
      end
      5'b00100, 5'b00101:                  // beqz, bnez
        nextOp.registerS = rx;
      5'b00110:                            // shifts by immediate
      begin
        nextOp.registerS = ry;
        nextOp.registerT = rx;
      end
      5'b01000:
      begin
        nextOp.opClass   = cpuPkg::OP_ADDIU;  // addiu3 ry = rx + imm4
        nextOp.registerS = rx;
        nextOp.registerT = ry;
        nextOp.imm       = imm4Sign;
      end
      5'b01001:
      begin
        // rx is both source and destination, so S is filled in too
        nextOp.opClass   = cpuPkg::OP_ADDIU;
        nextOp.registerS = rx;
        nextOp.registerT = rx;
        nextOp.imm       = imm8Sign;
      end
      5'b01010, 5'b01011, 5'b01110:        // slti, sltui, cmpi
        nextOp.registerS = rx;
      5'b01100:
        case (instWord[10:8])
          3'b011:
          begin
            nextOp.opClass   = cpuPkg::OP_ADDSP;
            nextOp.registerS = cpuPkg::REG_SP;
            nextOp.registerT = cpuPkg::REG_SP;
            nextOp.imm       = imm8Sign;
          end
          3'b100:
          begin
            nextOp.opClass   = cpuPkg::OP_MTSP;
            nextOp.registerS = ry;
            nextOp.registerT = cpuPkg::REG_SP;
          end
          default:
            nextOp.opClass = cpuPkg::OP_NONE;  // bteqz, btnez, sw_rs
        endcase
      5'b01101:
      begin
        nextOp.opClass   = cpuPkg::OP_LI;
        nextOp.registerT = rx;
        nextOp.imm       = imm8Zero;
      end
      5'b01111:
      begin
        nextOp.opClass   = cpuPkg::OP_MOVE;
        nextOp.registerS = ry;
        nextOp.registerT = rx;
      end
      5'b10010:
      begin
        nextOp.opClass   = cpuPkg::OP_LOAD;   // lw_sp
        nextOp.registerS = cpuPkg::REG_SP;
        nextOp.registerT = rx;
        nextOp.imm       = imm8Sign;
      end
      5'b10011:
      begin
        nextOp.opClass   = cpuPkg::OP_LOAD;
        nextOp.registerS = rx;
        nextOp.registerT = ry;
        nextOp.imm       = imm5Sign;
      end
      5'b11010:
      begin
        nextOp.opClass   = cpuPkg::OP_STORE;  // sw_sp stores rx
        nextOp.registerS = cpuPkg::REG_SP;
        nextOp.registerM = rx;
        nextOp.imm       = imm8Sign;
      end
      5'b11011:
      begin
        nextOp.opClass   = cpuPkg::OP_STORE;  // base ry, data rx
        nextOp.registerS = ry;
        nextOp.registerM = rx;
        nextOp.imm       = imm5Sign;
      end
      5'b11100:
      begin
        nextOp.registerS = rx;
        nextOp.registerM = ry;
        nextOp.registerT = rz;
        case (instWord[1:0])
          2'b01:   nextOp.opClass = cpuPkg::OP_ADDU;
          2'b11:   nextOp.opClass = cpuPkg::OP_SUBU;
          default: nextOp.opClass = cpuPkg::OP_NONE;
        endcase
      end
      5'b11101:
        case (instWord[4:0])
          5'b00000:                         // jump group, only index mapping
            case (instWord[7:5])
              3'b000:  nextOp.registerS = rx;
              3'b010:  nextOp.registerT = rx;
              3'b110:
              begin
                nextOp.registerS = rx;
                nextOp.registerT = cpuPkg::REG_RA;  // jalr links into ra
              end
              default: nextOp.registerS = '0;
            endcase
          5'b00010, 5'b00011:               // slt, sltu
          begin
            nextOp.registerS = rx;
            nextOp.registerM = ry;
          end
          5'b00100, 5'b00110, 5'b00111:     // shifts by register
          begin
            nextOp.registerS = ry;
            nextOp.registerM = rx;
            nextOp.registerT = ry;
          end
          5'b01010:                         // cmp
          begin
            nextOp.registerS = ry;
            nextOp.registerM = rx;
          end
          5'b01011, 5'b01111:               // neg, not
          begin
            nextOp.registerS = ry;
            nextOp.registerT = rx;
          end
          5'b01100, 5'b01101, 5'b01110:     // and, or, xor
          begin
            nextOp.registerS = ry;
            nextOp.registerM = rx;
            nextOp.registerT = rx;
            if (instWord[1:0] == 2'b00)
              nextOp.opClass = cpuPkg::OP_AND;
            else if (instWord[1:0] == 2'b01)
              nextOp.opClass = cpuPkg::OP_OR;
          end
          default:
            nextOp.opClass = cpuPkg::OP_NONE;
        endcase
      5'b11110:
        if (instWord[0])
        begin
          nextOp.registerS = rx;              // mtih
          nextOp.registerT = cpuPkg::REG_IH;
        end
        else
        begin
          nextOp.registerS = cpuPkg::REG_IH;  // mfih
          nextOp.registerT = rx;
        end
      default:
        nextOp.opClass = cpuPkg::OP_NONE;   // nop, b, int
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      opValid <= 1'b0;
    else if (instValid && instReady)
      opValid <= 1'b1;
    else if (opReady)
      opValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (instValid && instReady)
      op <= nextOp;  // held until execute takes it
  end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerFile (
  input  wire                  clk,
  input  wire                  rst,
  input  wire cpuPkg::regIdx_t readS,
  input  wire cpuPkg::regIdx_t readM,
  input  wire                  writeEn,
  input  wire cpuPkg::regIdx_t writeIdx,
  input  wire cpuPkg::word_t   writeData,
  output cpuPkg::word_t        dataS,
  output cpuPkg::word_t        dataM
);

  cpuPkg::word_t regs [cpuPkg::REG_COUNT];

  assign dataS = (int'(readS) < cpuPkg::REG_COUNT) ? regs[readS] : '0;
  assign dataM = (int'(readM) < cpuPkg::REG_COUNT) ? regs[readM] : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < cpuPkg::REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (writeEn && (int'(writeIdx) < cpuPkg::REG_COUNT))
      regs[writeIdx] <= writeData;  // 11..15 dropped
  end

endmodule

`default_nettype wire

// ==== src/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  localparam int WORD_W    = 16;
  localparam int REG_COUNT = 11;  // r0..r7 plus ih, sp, ra

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [3:0]        regIdx_t;

  localparam regIdx_t REG_IH   = 4'd8;
  localparam regIdx_t REG_SP   = 4'd9;
  localparam regIdx_t REG_RA   = 4'd10;
  localparam word_t   RESET_PC = '0;

  typedef enum logic [3:0] {
    OP_NONE,   // decoded but not executed
    OP_LI,
    OP_ADDIU,  // also addiu3
    OP_ADDU,
    OP_SUBU,
    OP_MOVE,
    OP_AND,
    OP_OR,
    OP_MTSP,
    OP_ADDSP,
    OP_LOAD,   // lw, lw_sp
    OP_STORE   // sw, sw_sp
  } opClass_t;

  typedef struct packed {
    opClass_t opClass;
    regIdx_t  registerS;
    regIdx_t  registerM;
    regIdx_t  registerT;
    word_t    imm;        // already extended
  } decodedOp_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } memReq_t;

endpackage

`default_nettype wire
